/* verilog/core_cfg_pkg.sv */
package core_cfg_pkg;

    // machine sizes
    localparam int NUM_ARCH  = 32;
    localparam int NUM_PHYS  = 40;
    localparam int ROB_DEPTH = 16;
    localparam int NUM_CPL   = 3;
    localparam int RETIRE_W  = 2;

    // physical registers left over once every architectural register is mapped
    localparam int FREE_DEPTH = NUM_PHYS - NUM_ARCH;

    // register numbers
    typedef logic [$clog2(NUM_ARCH)-1:0] arch_reg_t;
    typedef logic [$clog2(NUM_PHYS)-1:0] phys_reg_t;

    // rob pointers and occupancy
    typedef logic [$clog2(ROB_DEPTH)-1:0]   rob_idx_t;
    typedef logic [$clog2(ROB_DEPTH+1)-1:0] rob_cnt_t;

    // free list pointers and occupancy
    typedef logic [$clog2(FREE_DEPTH)-1:0]   free_idx_t;
    typedef logic [$clog2(FREE_DEPTH+1)-1:0] free_cnt_t;

    // payload
    typedef logic [31:0] pc_t;
    typedef logic [31:0] data_t;

endpackage

/* verilog/core_bus_pkg.sv */
package core_bus_pkg;

    import core_cfg_pkg::*;

    // instruction offered by the front end
    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_reg_t arch_dest;
        pc_t       pc;
    } dispatch_t;

    // rename result handed back to dispatch
    typedef struct packed {
        rob_idx_t  rob_idx;
        phys_reg_t new_phys;
    } rename_t;

    // accepted dispatch, rename_map to rob and ready table
    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_reg_t arch_dest;
        phys_reg_t new_phys;
        phys_reg_t old_phys;
        pc_t       pc;
    } alloc_t;

    // one execution unit completion
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        data_t    data;
    } complete_t;

    // result broadcast for the issue queue
    typedef struct packed {
        logic      valid;
        phys_reg_t phys;
        data_t     data;
    } wakeup_t;

    // one retire slot, arf write plus the mapping to free
    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_reg_t arch_dest;
        phys_reg_t old_phys;
        phys_reg_t new_phys;
        data_t     data;
        pc_t       pc;
    } retire_t;

endpackage

/* verilog/rename_map.sv */
module rename_map import core_cfg_pkg::*, core_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  dispatch_t              dispatch,
    input  logic                   rob_full,
    input  rob_idx_t               rob_tail,
    input  retire_t [RETIRE_W-1:0] retire,
    output logic                   stall,
    output rename_t                rename,
    output alloc_t                 alloc
);

    // speculative map table, arch -> phys
    phys_reg_t map_q [NUM_ARCH];

    // free list FIFO
    phys_reg_t free_q [FREE_DEPTH];
    free_idx_t free_head_q;
    free_idx_t free_tail_q;
    free_cnt_t free_cnt_q;

    logic                accept;
    logic                pop;
    logic                free_empty;
    phys_reg_t           free_head;
    logic [RETIRE_W-1:0] push;
    free_idx_t           wr_ptr [RETIRE_W];
    free_cnt_t           push_cnt;

    assign free_empty = (free_cnt_q == '0);
    assign free_head  = free_q[free_head_q];

    // stores only need a rob entry, so an empty free list does not block them
    assign stall  = rob_full || (dispatch.valid && dispatch.has_dest && free_empty);
    assign accept = dispatch.valid && !stall;
    assign pop    = accept && dispatch.has_dest;

    assign rename.rob_idx  = rob_tail;
    assign rename.new_phys = dispatch.has_dest ? free_head : '0;

    assign alloc.valid     = accept;
    assign alloc.has_dest  = dispatch.has_dest;
    assign alloc.arch_dest = dispatch.arch_dest;
    assign alloc.new_phys  = rename.new_phys;
    assign alloc.old_phys  = dispatch.has_dest ? map_q[dispatch.arch_dest] : '0;
    assign alloc.pc        = dispatch.pc;

    // retired old mappings go back in slot order
    always_comb begin
        push_cnt  = '0;
        wr_ptr[0] = free_tail_q;
        for (int i = 0; i < RETIRE_W; i++) begin
            push[i]  = retire[i].valid && retire[i].has_dest;
            push_cnt = push_cnt + free_cnt_t'(push[i]);
            if (i > 0) begin
                wr_ptr[i] = wr_ptr[i-1] + free_idx_t'(push[i-1]);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
        end else if (pop) begin
            map_q[dispatch.arch_dest] <= free_head;
        end
    end

    // reset leaves the spare registers queued in ascending order
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_q[i] <= phys_reg_t'(NUM_ARCH + i);
            end
            free_head_q <= '0;
            free_tail_q <= '0;
            free_cnt_q  <= free_cnt_t'(FREE_DEPTH);
        end else begin
            for (int i = 0; i < RETIRE_W; i++) begin
                if (push[i]) begin
                    free_q[wr_ptr[i]] <= retire[i].old_phys;
                end
            end
            if (pop) begin
                free_head_q <= free_head_q + 1'b1;
            end
            free_tail_q <= free_tail_q + free_idx_t'(push_cnt);
            free_cnt_q  <= free_cnt_q + push_cnt - free_cnt_t'(pop);
        end
    end

endmodule

/* verilog/reorder_buffer.sv */
module reorder_buffer import core_cfg_pkg::*, core_bus_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  alloc_t                  alloc,
    input  complete_t [NUM_CPL-1:0] complete,
    output logic                    rob_full,
    output rob_idx_t                rob_tail,
    output wakeup_t [NUM_CPL-1:0]   cpl_wakeup,
    output retire_t [RETIRE_W-1:0]  retire
);

    // entry control
    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] complete_q;

    // entry payload
    logic      has_dest_q  [ROB_DEPTH];
    arch_reg_t arch_dest_q [ROB_DEPTH];
    phys_reg_t new_phys_q  [ROB_DEPTH];
    phys_reg_t old_phys_q  [ROB_DEPTH];
    pc_t       pc_q        [ROB_DEPTH];
    data_t     data_q      [ROB_DEPTH];

    rob_idx_t head_q;
    rob_idx_t tail_q;
    rob_cnt_t count_q;

    rob_idx_t            ret_idx [RETIRE_W];
    logic [RETIRE_W-1:0] ret_go;
    rob_cnt_t            ret_cnt;

    assign rob_full = (count_q == rob_cnt_t'(ROB_DEPTH));
    assign rob_tail = tail_q;

    // translate each completion to the physical register it produces
    always_comb begin
        for (int p = 0; p < NUM_CPL; p++) begin
            // a store completes without writing a register, so it wakes nothing
            cpl_wakeup[p].valid = complete[p].valid && has_dest_q[complete[p].rob_idx];
            cpl_wakeup[p].phys  = new_phys_q[complete[p].rob_idx];
            cpl_wakeup[p].data  = complete[p].data;
        end
    end

    // pick up to RETIRE_W complete entries from the head, stop at the first gap
    always_comb begin
        logic in_order;
        in_order = 1'b1;
        ret_cnt  = '0;
        for (int i = 0; i < RETIRE_W; i++) begin
            ret_idx[i] = head_q + rob_idx_t'(i);
            ret_go[i]  = in_order && valid_q[ret_idx[i]] && complete_q[ret_idx[i]];
            in_order   = ret_go[i];
            ret_cnt    = ret_cnt + rob_cnt_t'(ret_go[i]);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q    <= '0;
            complete_q <= '0;
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
        end else begin
            for (int i = 0; i < RETIRE_W; i++) begin
                if (ret_go[i]) begin
                    valid_q[ret_idx[i]] <= 1'b0;
                end
            end
            for (int p = 0; p < NUM_CPL; p++) begin
                if (complete[p].valid) begin
                    complete_q[complete[p].rob_idx] <= 1'b1;
                end
            end
            // tail never meets a retiring entry since alloc is blocked when full
            if (alloc.valid) begin
                valid_q[tail_q]    <= 1'b1;
                complete_q[tail_q] <= 1'b0;
                tail_q             <= tail_q + 1'b1;
            end
            head_q  <= head_q + rob_idx_t'(ret_cnt);
            count_q <= count_q + rob_cnt_t'(alloc.valid) - ret_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            has_dest_q[tail_q]  <= alloc.has_dest;
            arch_dest_q[tail_q] <= alloc.arch_dest;
            new_phys_q[tail_q]  <= alloc.new_phys;
            old_phys_q[tail_q]  <= alloc.old_phys;
            pc_q[tail_q]        <= alloc.pc;
        end
        for (int p = 0; p < NUM_CPL; p++) begin
            if (complete[p].valid) begin
                data_q[complete[p].rob_idx] <= complete[p].data;
            end
        end
    end

    // registered retire, slot 1 only follows slot 0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            retire <= '0;
        end else begin
            for (int i = 0; i < RETIRE_W; i++) begin
                retire[i].valid     <= ret_go[i];
                retire[i].has_dest  <= has_dest_q[ret_idx[i]];
                retire[i].arch_dest <= arch_dest_q[ret_idx[i]];
                retire[i].old_phys  <= old_phys_q[ret_idx[i]];
                retire[i].new_phys  <= new_phys_q[ret_idx[i]];
                retire[i].data      <= data_q[ret_idx[i]];
                retire[i].pc        <= pc_q[ret_idx[i]];
            end
        end
    end

endmodule

/* verilog/ready_table.sv */
module ready_table import core_cfg_pkg::*, core_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  alloc_t                alloc,
    input  wakeup_t [NUM_CPL-1:0] cpl_wakeup,
    output wakeup_t [NUM_CPL-1:0] wakeup,
    output logic [NUM_PHYS-1:0]   phys_ready
);

    // every register starts out holding a committed value
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phys_ready <= '1;
        end else begin
            if (alloc.valid && alloc.has_dest) begin
                phys_ready[alloc.new_phys] <= 1'b0;
            end
            // set after the clear so a wakeup to the same register wins
            for (int p = 0; p < NUM_CPL; p++) begin
                if (cpl_wakeup[p].valid) begin
                    phys_ready[cpl_wakeup[p].phys] <= 1'b1;
                end
            end
        end
    end

    // broadcast to the issue queue one cycle after completion
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wakeup <= '0;
        end else begin
            wakeup <= cpl_wakeup;
        end
    end

endmodule

/* verilog/rob_backend.sv */
module rob_backend import core_cfg_pkg::*, core_bus_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  dispatch_t               dispatch,
    input  complete_t [NUM_CPL-1:0] complete,
    output logic                    stall,
    output rename_t                 rename,
    output wakeup_t [NUM_CPL-1:0]   wakeup,
    output logic [NUM_PHYS-1:0]     phys_ready,
    output retire_t [RETIRE_W-1:0]  retire
);

    logic                  rob_full;
    rob_idx_t              rob_tail;
    alloc_t                alloc;
    wakeup_t [NUM_CPL-1:0] cpl_wakeup;

    // retire also feeds the free list
    rename_map rename_map_inst (
        .clk      (clk),
        .rstn     (rstn),
        .dispatch (dispatch),
        .rob_full (rob_full),
        .rob_tail (rob_tail),
        .retire   (retire),
        .stall    (stall),
        .rename   (rename),
        .alloc    (alloc)
    );

    reorder_buffer reorder_buffer_inst (
        .clk        (clk),
        .rstn       (rstn),
        .alloc      (alloc),
        .complete   (complete),
        .rob_full   (rob_full),
        .rob_tail   (rob_tail),
        .cpl_wakeup (cpl_wakeup),
        .retire     (retire)
    );

    ready_table ready_table_inst (
        .clk        (clk),
        .rstn       (rstn),
        .alloc      (alloc),
        .cpl_wakeup (cpl_wakeup),
        .wakeup     (wakeup),
        .phys_ready (phys_ready)
    );

endmodule

/* dv/rob_backend_tb.sv */
module rob_backend_tb import core_cfg_pkg::*, core_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int DISP_CYCLES  = 400;
    localparam int DRAIN_CYCLES = 200;
    localparam int SLACK_CYCLES = 10;

    // model view of one rob entry
    typedef struct packed {
        logic      done;
        logic      has_dest;
        arch_reg_t arch_dest;
        phys_reg_t new_phys;
        phys_reg_t old_phys;
        pc_t       pc;
        data_t     data;
    } rob_entry_t;

    logic                    clk;
    logic                    rstn;
    dispatch_t               dispatch;
    complete_t [NUM_CPL-1:0] complete;
    logic                    stall;
    rename_t                 rename;
    wakeup_t [NUM_CPL-1:0]   wakeup;
    logic [NUM_PHYS-1:0]     phys_ready;
    retire_t [RETIRE_W-1:0]  retire;

    int seed = 32'ha3bb;

    // values currently on the DUT inputs
    dispatch_t               disp_cur;
    complete_t [NUM_CPL-1:0] cpl_cur;
    logic                    disp_taken;

    // reference model state
    phys_reg_t              map_m [NUM_ARCH];
    phys_reg_t              free_m [$];
    rob_entry_t             rob_m [ROB_DEPTH];
    rob_idx_t               order_m [$];
    rob_idx_t               tail_m;
    logic [NUM_PHYS-1:0]    ready_m;
    wakeup_t [NUM_CPL-1:0]  exp_wake;
    retire_t [RETIRE_W-1:0] exp_ret;

    rob_backend rob_backend_inst (
        .clk        (clk),
        .rstn       (rstn),
        .dispatch   (dispatch),
        .complete   (complete),
        .stall      (stall),
        .rename     (rename),
        .wakeup     (wakeup),
        .phys_ready (phys_ready),
        .retire     (retire)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned rand_below(int unsigned n);
        int unsigned r;
        r = $unsigned($random(seed));
        return r % n;
    endfunction

    // full rob, or a destination with nothing left on the free list
    function automatic logic model_stall(dispatch_t d);
        return (order_m.size() == ROB_DEPTH) ||
               (d.valid && d.has_dest && free_m.size() == 0);
    endfunction

    function automatic logic model_drained();
        return (order_m.size() == 0) && !disp_cur.valid &&
               !exp_ret[0].valid && !exp_ret[1].valid;
    endfunction

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_stall(logic got, logic exp);
        if (got !== exp) begin
            $display("ERR stall got %h exp %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_rename(rename_t got, rename_t exp);
        if (got !== exp) begin
            $display("ERR rename got %h exp %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_wakeup(int port, wakeup_t got, wakeup_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            $display("ERR wakeup[%0d] got %h exp %h", port, got, exp);
            abort_run();
        end
    endtask

    task automatic check_retire(int slot, retire_t got, retire_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            $display("ERR retire[%0d] got %h exp %h", slot, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ready(logic [NUM_PHYS-1:0] got, logic [NUM_PHYS-1:0] exp);
        if (got !== exp) begin
            $display("ERR phys_ready got %h exp %h", got, exp);
            abort_run();
        end
    endtask

    task automatic model_reset();
        free_m.delete();
        order_m.delete();
        for (int i = 0; i < NUM_ARCH; i++) begin
            map_m[i] = phys_reg_t'(i);
        end
        for (int i = NUM_ARCH; i < NUM_PHYS; i++) begin
            free_m.push_back(phys_reg_t'(i));
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            rob_m[i] = '0;
        end
        tail_m   = '0;
        ready_m  = '1;
        exp_wake = '0;
        exp_ret  = '0;
    endtask

    // what the design does at one rising edge, given the inputs it samples there
    task automatic model_edge();
        logic       accept;
        rob_entry_t e;
        int         n_ret;
        accept     = disp_cur.valid && !model_stall(disp_cur);
        disp_taken = accept;
        // mappings released by last cycle's retire output
        for (int i = 0; i < RETIRE_W; i++) begin
            if (exp_ret[i].valid && exp_ret[i].has_dest) begin
                free_m.push_back(exp_ret[i].old_phys);
            end
        end
        // oldest completed entries leave in order up to the first gap
        n_ret = 0;
        for (int i = 0; i < RETIRE_W; i++) begin
            exp_ret[i] = '0;
            if (n_ret == i && i < order_m.size() && rob_m[order_m[i]].done) begin
                e                    = rob_m[order_m[i]];
                exp_ret[i].valid     = 1'b1;
                exp_ret[i].has_dest  = e.has_dest;
                exp_ret[i].arch_dest = e.arch_dest;
                exp_ret[i].old_phys  = e.old_phys;
                exp_ret[i].new_phys  = e.new_phys;
                exp_ret[i].data      = e.data;
                exp_ret[i].pc        = e.pc;
                n_ret++;
            end
        end
        repeat (n_ret) void'(order_m.pop_front());
        if (accept) begin
            e           = '0;
            e.has_dest  = disp_cur.has_dest;
            e.arch_dest = disp_cur.arch_dest;
            e.pc        = disp_cur.pc;
            if (disp_cur.has_dest) begin
                e.new_phys                 = free_m.pop_front();
                e.old_phys                 = map_m[disp_cur.arch_dest];
                map_m[disp_cur.arch_dest]  = e.new_phys;
                ready_m[e.new_phys]        = 1'b0;
            end
            rob_m[tail_m] = e;
            order_m.push_back(tail_m);
            tail_m = tail_m + rob_idx_t'(1);
        end
        // completions go last so a wakeup beats a clear of the same register
        for (int p = 0; p < NUM_CPL; p++) begin
            exp_wake[p] = '0;
            if (cpl_cur[p].valid) begin
                rob_m[cpl_cur[p].rob_idx].done = 1'b1;
                rob_m[cpl_cur[p].rob_idx].data = cpl_cur[p].data;
                if (rob_m[cpl_cur[p].rob_idx].has_dest) begin
                    exp_wake[p].valid     = 1'b1;
                    exp_wake[p].phys      = rob_m[cpl_cur[p].rob_idx].new_phys;
                    exp_wake[p].data      = cpl_cur[p].data;
                    ready_m[exp_wake[p].phys] = 1'b1;
                end
            end
        end
    endtask

    task automatic pick_stimulus(input logic allow);
        rob_idx_t    cand [$];
        int unsigned k;
        int unsigned rate;
        // a stalled dispatch stays on the bus until it is taken
        if (!(disp_cur.valid && !disp_taken)) begin
            disp_cur = '0;
            if (allow && rand_below(4) != 0) begin
                disp_cur.valid     = 1'b1;
                disp_cur.has_dest  = (rand_below(10) >= 3);
                disp_cur.arch_dest = arch_reg_t'(rand_below(NUM_ARCH));
                // small pc range so loops revisit the same addresses
                disp_cur.pc        = pc_t'(32'h1000 + 4 * rand_below(64));
            end
        end
        foreach (order_m[i]) begin
            if (!rob_m[order_m[i]].done) begin
                cand.push_back(order_m[i]);
            end
        end
        rate = allow ? 3 : 1;
        for (int p = 0; p < NUM_CPL; p++) begin
            cpl_cur[p] = '0;
            if (cand.size() != 0 && rand_below(rate) == 0) begin
                k                  = rand_below(cand.size());
                cpl_cur[p].valid   = 1'b1;
                cpl_cur[p].rob_idx = cand[k];
                cpl_cur[p].data    = data_t'($random(seed));
                cand.delete(k);
            end
        end
    endtask

    task automatic check_outputs();
        rename_t exp_ren;
        logic    exp_stall;
        exp_stall = model_stall(disp_cur);
        check_stall(stall, exp_stall);
        if (disp_cur.valid && !exp_stall) begin
            exp_ren.rob_idx  = tail_m;
            exp_ren.new_phys = disp_cur.has_dest ? free_m[0] : '0;
            check_rename(rename, exp_ren);
        end
        for (int p = 0; p < NUM_CPL; p++) begin
            check_wakeup(p, wakeup[p], exp_wake[p]);
        end
        if (retire[1].valid && !retire[0].valid) begin
            $display("retire slot 1 was valid while slot 0 was idle");
            abort_run();
        end
        for (int i = 0; i < RETIRE_W; i++) begin
            check_retire(i, retire[i], exp_ret[i]);
        end
        check_ready(phys_ready, ready_m);
    endtask

    // drive on the rising edge and check half a period later
    task automatic step_cycle(input logic allow);
        @(posedge clk);
        model_edge();
        pick_stimulus(allow);
        dispatch <= disp_cur;
        complete <= cpl_cur;
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        dispatch   = '0;
        complete   = '0;
        disp_cur   = '0;
        cpl_cur    = '0;
        disp_taken = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_outputs();
        for (int c = 0; c < DISP_CYCLES; c++) begin
            step_cycle(1'b1);
        end
        for (int c = 0; c < DRAIN_CYCLES && !model_drained(); c++) begin
            step_cycle(1'b0);
        end
        if (model_drained() && stall === 1'b0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("rob did not drain, or stall stayed high after the drain");
            $display("TB FAILED");
            $fatal(1);
        end
    end

    // watchdog sized from reset, dispatch phase and drain phase
    initial begin
        #((RESET_CYCLES + DISP_CYCLES + DRAIN_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the run completed");
        $display("TB FAILED");
        $fatal(1);
    end

endmodule

/* compile.f */
verilog/core_cfg_pkg.sv
verilog/core_bus_pkg.sv
verilog/rename_map.sv
verilog/reorder_buffer.sv
verilog/ready_table.sv
verilog/rob_backend.sv
dv/rob_backend_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the rob backend testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

TOP=rob_backend_tb
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f compile.f \
    --Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status, see $LOG"
fi

if grep -q "^TB PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1
